/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -Wno-fatal
TOP       := tb_codec_i2c_init
FILELIST  := sim.f
LOG       := sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "Simulation completed successfully" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* rtl/codec_i2c_init.sv */
`timescale 1ns/1ps

module codec_i2c_init (
    input  logic i_clk,
    input  logic i_rst_n,
    input  logic i_start,
    input  logic i_sda,
    output logic o_scl_oe,
    output logic o_sda_oe,
    output logic o_busy,
    output logic o_done,
    output logic o_error
);

    logic                                frame_start;
    logic [i2c_init_pkg::frame_bits-1:0] frame_data;
    logic                                frame_done;
    logic                                frame_nack;
    i2c_init_pkg::bus_cmd_t              bus_cmd;
    i2c_init_pkg::ack_result_t           ack;

    init_sequencer seq_i (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_start       (i_start),
        .i_frame_done  (frame_done),
        .i_frame_nack  (frame_nack),
        .o_frame_start (frame_start),
        .o_frame_data  (frame_data),
        .o_busy        (o_busy),
        .o_done        (o_done),
        .o_error       (o_error)
    );

    i2c_frame_engine engine_i (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_frame_start (frame_start),
        .i_frame_data  (frame_data),
        .i_ack         (ack),
        .o_bus_cmd     (bus_cmd),
        .o_frame_done  (frame_done),
        .o_frame_nack  (frame_nack)
    );

    i2c_line_driver driver_i (
        .i_clk     (i_clk),
        .i_rst_n   (i_rst_n),
        .i_bus_cmd (bus_cmd),
        .i_sda     (i_sda),
        .o_scl_oe  (o_scl_oe),
        .o_sda_oe  (o_sda_oe),
        .o_ack     (ack)
    );

endmodule

/* rtl/i2c_frame_engine.sv */
`timescale 1ns/1ps

module i2c_frame_engine (
    input  logic                                i_clk,
    input  logic                                i_rst_n,
    input  logic                                i_frame_start,
    input  logic [i2c_init_pkg::frame_bits-1:0] i_frame_data,
    input  i2c_init_pkg::ack_result_t           i_ack,
    output i2c_init_pkg::bus_cmd_t              o_bus_cmd,
    output logic                                o_frame_done,
    output logic                                o_frame_nack
);

    localparam logic [2:0] last_bit = 3'(i2c_init_pkg::byte_bits - 1);
    localparam logic [1:0] last_byte = 2'(i2c_init_pkg::frame_bytes - 1);

    i2c_init_pkg::frame_state_e state_q;
    i2c_init_pkg::frame_state_e state_nx;

    logic [i2c_init_pkg::frame_bits-1:0] shift_q;
    logic [2:0] bit_cnt_q;
    logic [2:0] bit_cnt_nx;
    logic [1:0] byte_cnt_q;
    logic [1:0] byte_cnt_nx;
    logic       ack_wait_q;
    logic       ack_wait_nx;
    logic       nack_q;
    logic       nack_nx;
    logic       stop_q;
    logic       done_q;

    always_comb begin
        state_nx = state_q;
        bit_cnt_nx = bit_cnt_q;
        byte_cnt_nx = byte_cnt_q;
        ack_wait_nx = ack_wait_q;
        nack_nx = nack_q;
        case (state_q)
            i2c_init_pkg::FRM_IDLE: begin
                if (i_frame_start) begin
                    bit_cnt_nx = '0;
                    byte_cnt_nx = '0;
                    nack_nx = 1'b0;
                    state_nx = i2c_init_pkg::FRM_START;
                end
            end
            i2c_init_pkg::FRM_START: begin
                state_nx = i2c_init_pkg::FRM_BIT_LOW;
            end
            i2c_init_pkg::FRM_BIT_LOW: begin
                state_nx = i2c_init_pkg::FRM_BIT_HIGH;
            end
            i2c_init_pkg::FRM_BIT_HIGH: begin
                if (bit_cnt_q == last_bit) begin
                    bit_cnt_nx = '0;
                    state_nx = i2c_init_pkg::FRM_ACK_LOW;
                end else begin
                    bit_cnt_nx = bit_cnt_q + 1'b1;
                    state_nx = i2c_init_pkg::FRM_BIT_LOW;
                end
            end
            i2c_init_pkg::FRM_ACK_LOW: begin
                // second visit holds scl low until the slot is judged.
                if (!ack_wait_q) begin
                    state_nx = i2c_init_pkg::FRM_ACK_HIGH;
                end else if (i_ack.valid) begin
                    ack_wait_nx = 1'b0;
                    if (i_ack.nack) begin
                        nack_nx = 1'b1;
                        state_nx = i2c_init_pkg::FRM_STOP_LOW;
                    end else if (byte_cnt_q == last_byte) begin
                        state_nx = i2c_init_pkg::FRM_STOP_LOW;
                    end else begin
                        byte_cnt_nx = byte_cnt_q + 1'b1;
                        state_nx = i2c_init_pkg::FRM_BIT_LOW;
                    end
                end
            end
            i2c_init_pkg::FRM_ACK_HIGH: begin
                ack_wait_nx = 1'b1;
                state_nx = i2c_init_pkg::FRM_ACK_LOW;
            end
            i2c_init_pkg::FRM_STOP_LOW: begin
                state_nx = i2c_init_pkg::FRM_STOP_HIGH;
            end
            i2c_init_pkg::FRM_STOP_HIGH: begin
                state_nx = i2c_init_pkg::FRM_IDLE;
            end
            default: begin
                state_nx = i2c_init_pkg::FRM_IDLE;
            end
        endcase
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state_q <= i2c_init_pkg::FRM_IDLE;
            bit_cnt_q <= '0;
            byte_cnt_q <= '0;
            ack_wait_q <= 1'b0;
            nack_q <= 1'b0;
            stop_q <= 1'b0;
            done_q <= 1'b0;
        end else begin
            state_q <= state_nx;
            bit_cnt_q <= bit_cnt_nx;
            byte_cnt_q <= byte_cnt_nx;
            ack_wait_q <= ack_wait_nx;
            nack_q <= nack_nx;
            stop_q <= (state_q == i2c_init_pkg::FRM_STOP_HIGH);
            // lines up with sda release on the pin.
            done_q <= stop_q;
        end
    end

    // msb first.
    always_ff @(posedge i_clk) begin
        if (state_q == i2c_init_pkg::FRM_IDLE && i_frame_start) begin
            shift_q <= i_frame_data;
        end else if (state_q == i2c_init_pkg::FRM_BIT_HIGH) begin
            shift_q <= {shift_q[i2c_init_pkg::frame_bits-2:0], 1'b0};
        end
    end

    always_comb begin
        o_bus_cmd = '0;
        case (state_q)
            i2c_init_pkg::FRM_START: begin
                o_bus_cmd.sda_low = 1'b1;
            end
            i2c_init_pkg::FRM_BIT_LOW: begin
                o_bus_cmd.scl_low = 1'b1;
                o_bus_cmd.sda_low = ~shift_q[i2c_init_pkg::frame_bits-1];
            end
            i2c_init_pkg::FRM_BIT_HIGH: begin
                o_bus_cmd.sda_low = ~shift_q[i2c_init_pkg::frame_bits-1];
            end
            i2c_init_pkg::FRM_ACK_LOW: begin
                o_bus_cmd.scl_low = 1'b1;
            end
            i2c_init_pkg::FRM_ACK_HIGH: begin
                o_bus_cmd.ack_slot = 1'b1;
            end
            i2c_init_pkg::FRM_STOP_LOW: begin
                o_bus_cmd.scl_low = 1'b1;
                o_bus_cmd.sda_low = 1'b1;
            end
            i2c_init_pkg::FRM_STOP_HIGH: begin
                o_bus_cmd.sda_low = 1'b1;
            end
            default: begin
                o_bus_cmd = '0;
            end
        endcase
    end

    assign o_frame_done = done_q;
    assign o_frame_nack = nack_q;

endmodule

/* rtl/i2c_init_pkg.sv */
package i2c_init_pkg;

    // setup sequence size.
    localparam int word_count = 7;
    localparam int frame_bits = 24;

    // frame layout.
    localparam int byte_bits = 8;
    localparam int frame_bytes = frame_bits / byte_bits;

    // engine cycles from start to stop, including the ack wait cycles.
    localparam int frame_cycles = 1 + frame_bytes * (2 * byte_bits + 4) + 2;

    // device address 0x34, then reg address [15:9] and data [8:0].
    localparam logic [frame_bits-1:0] setup_table [word_count] = '{
        24'h34_1201,  // active.
        24'h34_1019,  // sampling control.
        24'h34_0E42,  // digital audio interface format.
        24'h34_0C00,  // power down control.
        24'h34_0A00,  // digital path.
        24'h34_0815,  // analog path.
        24'h34_1E00   // reset register.
    };

    typedef logic [2:0] word_idx_t;

    typedef enum logic [2:0] {
        SEQ_IDLE,
        SEQ_LAUNCH,
        SEQ_WAIT,
        SEQ_DONE,
        SEQ_ERROR
    } seq_state_e;

    typedef enum logic [2:0] {
        FRM_IDLE,
        FRM_START,
        FRM_BIT_LOW,
        FRM_BIT_HIGH,
        FRM_ACK_LOW,
        FRM_ACK_HIGH,
        FRM_STOP_LOW,
        FRM_STOP_HIGH
    } frame_state_e;

    // engine request for the next bus cycle.
    typedef struct packed {
        logic scl_low;
        logic sda_low;
        logic ack_slot;
    } bus_cmd_t;

    // judged acknowledge slot.
    typedef struct packed {
        logic valid;
        logic nack;
    } ack_result_t;

endpackage

/* rtl/i2c_line_driver.sv */
`timescale 1ns/1ps

module i2c_line_driver (
    input  logic                      i_clk,
    input  logic                      i_rst_n,
    input  i2c_init_pkg::bus_cmd_t    i_bus_cmd,
    input  logic                      i_sda,
    output logic                      o_scl_oe,
    output logic                      o_sda_oe,
    output i2c_init_pkg::ack_result_t o_ack
);

    logic sda_meta;
    logic sda_sync;
    logic slot_q1;
    logic slot_q2;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_scl_oe <= 1'b0;
            o_sda_oe <= 1'b0;
            sda_meta <= 1'b1;
            sda_sync <= 1'b1;
            slot_q1 <= 1'b0;
            slot_q2 <= 1'b0;
        end else begin
            o_scl_oe <= i_bus_cmd.scl_low;
            o_sda_oe <= i_bus_cmd.sda_low;
            sda_meta <= i_sda;
            sda_sync <= sda_meta;
            // slot flag follows the same two stages as sda.
            slot_q1 <= i_bus_cmd.ack_slot;
            slot_q2 <= slot_q1;
        end
    end

    // sda as scl rose on the slot, high means no ack.
    always_comb begin
        o_ack.valid = slot_q2;
        o_ack.nack = slot_q2 & sda_sync;
    end

endmodule

/* rtl/init_sequencer.sv */
`timescale 1ns/1ps

module init_sequencer (
    input  logic                                i_clk,
    input  logic                                i_rst_n,
    input  logic                                i_start,
    input  logic                                i_frame_done,
    input  logic                                i_frame_nack,
    output logic                                o_frame_start,
    output logic [i2c_init_pkg::frame_bits-1:0] o_frame_data,
    output logic                                o_busy,
    output logic                                o_done,
    output logic                                o_error
);

    i2c_init_pkg::seq_state_e state_q;
    i2c_init_pkg::seq_state_e state_nx;
    i2c_init_pkg::word_idx_t  idx_q;
    i2c_init_pkg::word_idx_t  idx_nx;
    logic                     load_nx;
    logic [i2c_init_pkg::frame_bits-1:0] data_q;

    always_comb begin
        state_nx = state_q;
        idx_nx = idx_q;
        load_nx = 1'b0;
        case (state_q)
            i2c_init_pkg::SEQ_IDLE,
            i2c_init_pkg::SEQ_ERROR: begin
                // a new start also clears a latched error.
                if (i_start) begin
                    idx_nx = '0;
                    load_nx = 1'b1;
                    state_nx = i2c_init_pkg::SEQ_LAUNCH;
                end
            end
            i2c_init_pkg::SEQ_LAUNCH: begin
                state_nx = i2c_init_pkg::SEQ_WAIT;
            end
            i2c_init_pkg::SEQ_WAIT: begin
                if (i_frame_done) begin
                    if (i_frame_nack) begin
                        state_nx = i2c_init_pkg::SEQ_ERROR;
                    end else if (idx_q ==
                                 i2c_init_pkg::word_idx_t'(i2c_init_pkg::word_count - 1)) begin
                        state_nx = i2c_init_pkg::SEQ_DONE;
                    end else begin
                        idx_nx = idx_q + 1'b1;
                        load_nx = 1'b1;
                        state_nx = i2c_init_pkg::SEQ_LAUNCH;
                    end
                end
            end
            i2c_init_pkg::SEQ_DONE: begin
                state_nx = i2c_init_pkg::SEQ_IDLE;
            end
            default: begin
                state_nx = i2c_init_pkg::SEQ_IDLE;
            end
        endcase
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state_q <= i2c_init_pkg::SEQ_IDLE;
            idx_q <= '0;
        end else begin
            state_q <= state_nx;
            idx_q <= idx_nx;
        end
    end

    // word held for the whole frame.
    always_ff @(posedge i_clk) begin
        if (load_nx) begin
            data_q <= i2c_init_pkg::setup_table[idx_nx];
        end
    end

    assign o_frame_start = (state_q == i2c_init_pkg::SEQ_LAUNCH);
    assign o_frame_data = data_q;
    assign o_busy = (state_q == i2c_init_pkg::SEQ_LAUNCH) ||
                    (state_q == i2c_init_pkg::SEQ_WAIT);
    assign o_done = (state_q == i2c_init_pkg::SEQ_DONE);
    assign o_error = (state_q == i2c_init_pkg::SEQ_ERROR);

endmodule

/* sim.f */
rtl/i2c_init_pkg.sv
rtl/init_sequencer.sv
rtl/i2c_frame_engine.sv
rtl/i2c_line_driver.sv
rtl/codec_i2c_init.sv
verif/i2c_init_assertions.sv
verif/tb_codec_i2c_init.sv

/* verif/i2c_init_assertions.sv */
`timescale 1ns/1ps

module i2c_init_assertions (
    input logic i_clk,
    input logic i_rst_n,
    input logic i_scl_oe,
    input logic i_sda_oe,
    input logic i_done,
    input logic i_error
);

    int fail_count = 0;

    // with scl released, sda may only move for start or stop.
    property sda_moves_with_scl_low;
        @(posedge i_clk) disable iff (!i_rst_n)
            (i_sda_oe != $past(i_sda_oe)) && !i_scl_oe |-> !$past(i_scl_oe);
    endproperty

    property done_excludes_error;
        @(posedge i_clk) disable iff (!i_rst_n)
            !(i_done && i_error);
    endproperty

    property done_single_cycle;
        @(posedge i_clk) disable iff (!i_rst_n)
            i_done |=> !i_done;
    endproperty

    sda_scl_order: assert property (sda_moves_with_scl_low)
        else begin
            $error("sda enable changed as scl was released");
            fail_count++;
        end
    done_error_excl: assert property (done_excludes_error)
        else begin
            $error("o_done and o_error high together");
            fail_count++;
        end
    done_pulse: assert property (done_single_cycle)
        else begin
            $error("o_done held longer than one cycle");
            fail_count++;
        end

endmodule

bind codec_i2c_init i2c_init_assertions chk_i (
    .i_clk    (i_clk),
    .i_rst_n  (i_rst_n),
    .i_scl_oe (o_scl_oe),
    .i_sda_oe (o_sda_oe),
    .i_done   (o_done),
    .i_error  (o_error)
);

/* verif/tb_codec_i2c_init.sv */
`timescale 1ns/1ps

module tb_codec_i2c_init;

    typedef struct packed {
        logic [31:0] data;
        logic [5:0]  nbits;
    } frame_rec_t;

    localparam int seq_cycles = i2c_init_pkg::word_count * (i2c_init_pkg::frame_cycles + 8);
    localparam int settle_cycles = i2c_init_pkg::frame_cycles + 20;
    // three full runs, the aborted run and the settle windows.
    localparam int watchdog_cycles = 4 * seq_cycles + 1000;

    logic i_clk;
    logic i_rst_n;
    logic i_start;
    logic o_scl_oe;
    logic o_sda_oe;
    logic o_busy;
    logic o_done;
    logic o_error;
    logic slave_sda_low;
    logic scl;
    logic sda;

    frame_rec_t  frames[$];
    logic [31:0] lcg_state = 32'd68;
    int          errors = 0;
    int          tests_run = 0;
    int          tests_failed = 0;
    int          done_count = 0;
    int          start_count = 0;
    bit          nack_armed = 1'b0;
    int          nack_frame = 0;
    int          nack_byte = 0;

    // open drain, low if either side pulls.
    assign scl = ~o_scl_oe;
    assign sda = ~(o_sda_oe | slave_sda_low);

    codec_i2c_init dut_i (
        .i_clk    (i_clk),
        .i_rst_n  (i_rst_n),
        .i_start  (i_start),
        .i_sda    (sda),
        .o_scl_oe (o_scl_oe),
        .o_sda_oe (o_sda_oe),
        .o_busy   (o_busy),
        .o_done   (o_done),
        .o_error  (o_error)
    );

    initial begin
        i_clk = 1'b0;
        forever #10 i_clk = ~i_clk;
    end

    initial begin
        repeat (watchdog_cycles) @(posedge i_clk);
        $display("watchdog expired after %0d cycles, the DUT never finished", watchdog_cycles);
        $display("Simulation failed");
        $finish;
    end

    // slave, sampled mid-cycle.
    initial begin : slave_model
        logic       prev_scl;
        logic       prev_sda;
        logic       in_frame;
        logic       last_data;
        int         pos;
        frame_rec_t rec;
        slave_sda_low = 1'b0;
        prev_scl = 1'b1;
        prev_sda = 1'b1;
        in_frame = 1'b0;
        last_data = 1'b0;
        pos = 0;
        rec = '0;
        forever begin
            @(negedge i_clk);
            if (prev_scl && scl && prev_sda && !sda) begin
                start_count++;
                in_frame = 1'b1;
                pos = 0;
                rec = '0;
            end else if (prev_scl && scl && !prev_sda && sda && in_frame) begin
                // the last rise was the stop.
                if (last_data) begin
                    rec.data = rec.data >> 1;
                    rec.nbits = rec.nbits - 1'b1;
                end
                frames.push_back(rec);
                in_frame = 1'b0;
            end else if (!prev_scl && scl && in_frame) begin
                last_data = (pos % 9 != 8);
                if (last_data) begin
                    rec.data = {rec.data[30:0], sda};
                    rec.nbits = rec.nbits + 1'b1;
                end
                pos++;
            end else if (prev_scl && !scl && in_frame) begin
                slave_sda_low = (pos % 9 == 8) && !(nack_armed &&
                                start_count - 1 == nack_frame && pos / 9 == nack_byte);
            end
            prev_scl = scl;
            prev_sda = sda;
        end
    end

    always @(negedge i_clk) begin
        if (o_done) begin
            done_count++;
        end
    end

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        assert (got === exp) else begin
            errors++;
            $display("ERROR at %0t ns: %s = 0x%0h, expected 0x%0h", $time, name, got, exp);
        end
    endtask

    task automatic expect_true(input logic cond, input string what);
        assert (cond) else begin
            errors++;
            $display("check failed at %0t ns: %s", $time, what);
        end
    endtask

    task automatic pulse_start();
        @(negedge i_clk);
        i_start = 1'b1;
        @(negedge i_clk);
        i_start = 1'b0;
    endtask

    task automatic wait_for_end();
        while (!(o_done || o_error)) begin
            @(negedge i_clk);
        end
    endtask

    task automatic check_frames(input int base, input int count, input int last_bits);
        int bits;
        compare_value("captured frames", frames.size() - base, count);
        for (int k = 0; k < count && base + k < frames.size(); k++) begin
            bits = (k == count - 1) ? last_bits : i2c_init_pkg::frame_bits;
            compare_value($sformatf("frame %0d bits", k), frames[base + k].nbits, bits);
            compare_value($sformatf("frame %0d data", k), frames[base + k].data,
                          i2c_init_pkg::setup_table[k] >> (i2c_init_pkg::frame_bits - bits));
        end
    endtask

    task automatic finish_test(input string name, input int errors_before);
        tests_run++;
        if (errors == errors_before) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", name, errors - errors_before);
        end
    endtask

    task automatic test_idle_after_reset();
        int err0;
        err0 = errors;
        compare_value("o_scl_oe", o_scl_oe, 0);
        compare_value("o_sda_oe", o_sda_oe, 0);
        compare_value("o_busy", o_busy, 0);
        compare_value("o_done", o_done, 0);
        compare_value("o_error", o_error, 0);
        finish_test("idle_after_reset", err0);
    endtask

    task automatic test_full_sequence(input string name, input bit second_start);
        int err0;
        int fbase;
        int sbase;
        int dbase;
        err0 = errors;
        fbase = frames.size();
        sbase = start_count;
        dbase = done_count;
        pulse_start();
        compare_value("o_error", o_error, 0);
        compare_value("o_busy", o_busy, 1);
        if (second_start) begin
            while (frames.size() < fbase + 2) begin
                @(negedge i_clk);
            end
            // land in the middle of the third frame.
            repeat (i2c_init_pkg::frame_cycles / 2) @(negedge i_clk);
            compare_value("o_busy", o_busy, 1);
            pulse_start();
        end
        wait_for_end();
        repeat (settle_cycles) @(negedge i_clk);
        compare_value("o_busy", o_busy, 0);
        compare_value("o_error", o_error, 0);
        compare_value("done pulses", done_count - dbase, 1);
        compare_value("start conditions", start_count - sbase, i2c_init_pkg::word_count);
        check_frames(fbase, i2c_init_pkg::word_count, i2c_init_pkg::frame_bits);
        finish_test(name, err0);
    endtask

    task automatic test_nack_abort();
        int          err0;
        int          fbase;
        int          dbase;
        int          frame_idx;
        logic [31:0] r;
        err0 = errors;
        fbase = frames.size();
        dbase = done_count;
        r = next_random();
        frame_idx = int'((r >> 16) % i2c_init_pkg::word_count);
        r = next_random();
        nack_byte = int'((r >> 16) % i2c_init_pkg::frame_bytes);
        nack_frame = start_count + frame_idx;
        nack_armed = 1'b1;
        $display("nack planned at frame %0d, byte %0d", frame_idx, nack_byte);
        pulse_start();
        wait_for_end();
        repeat (settle_cycles) @(negedge i_clk);
        nack_armed = 1'b0;
        compare_value("o_error", o_error, 1);
        compare_value("o_busy", o_busy, 0);
        compare_value("done pulses", done_count - dbase, 0);
        compare_value("start conditions", start_count - nack_frame, 1);
        expect_true(scl && sda, "bus not released after the aborted frame");
        check_frames(fbase, frame_idx + 1, 8 * (nack_byte + 1));
        finish_test("nack_abort", err0);
    endtask

    initial begin
        i_rst_n = 1'b0;
        i_start = 1'b0;
        repeat (3) @(negedge i_clk);
        i_rst_n = 1'b1;
        @(negedge i_clk);
        test_idle_after_reset();
        test_full_sequence("full_sequence", 1'b0);
        test_full_sequence("start_while_busy", 1'b1);
        test_nack_abort();
        test_full_sequence("recovery", 1'b0);
        $display("summary: %0d tests, %0d failed, %0d check errors, %0d assertion failures",
                 tests_run, tests_failed, errors, dut_i.chk_i.fail_count);
        if (errors == 0 && dut_i.chk_i.fail_count == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule
